/* verif/exe_cases.txt */
// cols: pc da db imm bpc mem_word jidx fn af mf, then expected wb ec store_word next_pc
// fn: alu func, branch kind, target reg (2 digits); one digit per flag in af, mf and ec
// af: alu_imm shift_imm link slt slt_sign allow_ovf reg_write
// mf: load store lane_op b_hw load_sign canceled; ec: reg_write store_en cause
100 5 3 0 0 0 0 0003 0000001 000000 8 100 0 104
104 10 3 0 0 0 0 1004 0000001 000000 d 100 0 108
108 f0f0 0 ff 0 0 0 2005 1000001 000000 f0 100 0 10c
10c f000 f0f 0 0 0 0 3006 0000001 000000 ff0f 100 0 110
110 ff00 ff0 0 0 0 0 4007 0000001 000000 f0f0 100 0 114
114 f0f0f0f0 f0f0f00 0 0 0 0 5008 0000001 000000 f 100 0 118
118 0 1 100 0 0 0 6009 0100001 000000 10 100 0 11c
11c 8 80000000 0 0 0 0 700a 0000001 000000 800000 100 0 120
120 0 80000000 100 0 0 0 800b 0100001 000000 f8000000 100 0 124
124 7fffffff 1 0 0 0 0 000c 0000011 000000 80000000 007 0 128
128 7fffffff 1 0 0 0 0 000c 0000001 000000 80000000 100 0 12c
12c ffffffff 1 0 0 0 0 000d 0001101 000000 1 100 0 130
130 ffffffff 1 0 0 0 0 000d 0001001 000000 0 100 0 134
134 0 0 0 0 0 1000 0100 0010001 000000 138 100 0 4000
138 2000 0 0 0 0 0 0200 0000000 000000 0 000 0 2000
90000000 0 0 0 0 0 123 0100 0000000 000000 0 000 0 9000048c
140 5 5 0 400 0 0 0300 0000000 000000 0 000 0 400
144 5 6 0 400 0 0 0300 0000000 000000 0 000 0 148
148 5 6 0 500 0 0 0400 0000000 000000 0 000 0 500
14c 5 5 0 500 0 0 0400 0000000 000000 0 000 0 150
150 0 0 0 600 0 0 0500 0000000 000000 0 000 0 600
154 1 0 0 600 0 0 0500 0000000 000000 0 000 0 158
158 1 0 0 700 0 0 0600 0000000 000000 0 000 0 700
15c 0 0 0 700 0 0 0600 0000000 000000 0 000 0 160
160 80000000 0 0 800 0 0 0700 0000000 000000 0 000 0 800
164 0 0 0 800 0 0 0700 0000000 000000 0 000 0 168
168 0 0 0 900 0 0 0800 0000000 000000 0 000 0 900
16c ffffffff 0 0 900 0 0 0800 0000000 000000 0 000 0 170
170 1000 0 0 0 807fc321 0 0004 1000001 101010 ffffff80 100 0 174
174 1000 0 1 0 807fc321 0 0004 1000001 101000 7f 100 0 178
178 1000 0 2 0 807fc321 0 0004 1000001 101010 ffffffc3 100 0 17c
17c 1000 0 3 0 807fc321 0 0004 1000001 101000 21 100 0 180
180 1000 0 0 0 807fc321 0 0004 1000001 101110 ffff807f 100 0 184
184 1000 0 2 0 807fc321 0 0004 1000001 101100 c321 100 0 188
188 1000 0 0 0 807fc321 0 0004 1000001 100000 807fc321 100 0 18c
18c 1000 a5 1 0 807fc321 0 0000 1000000 011000 0 010 80a5c321 190
190 1000 beef 2 0 807fc321 0 0000 1000000 011100 0 010 807fbeef 194
194 1000 12345678 0 0 807fc321 0 0000 1000000 010000 0 010 12345678 198
198 1000 0 1 0 807fc321 0 0004 1000001 101110 0 008 0 19c
19c 1000 12345678 2 0 807fc321 0 0000 1000000 010000 0 008 0 1a0
1a0 7fffffff 1 0 0 0 0 000c 0000011 000001 0 000 0 1a4
1a4 1000 a5 0 0 807fc321 0 0000 1000000 011001 0 000 0 1a8

/* list.f */
src/exe_pkg.sv
src/exe_issue_reg.sv
src/alu.sv
src/branch_resolve.sv
src/exe_stage.sv
src/lane_align.sv
src/exe_pipe_top.sv
verif/tb_exe_pipe.sv

/* Makefile */
# verilator build and run of the execute pipe testbench
TOP = tb_exe_pipe
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run and search $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx 'Done: no errors' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verif/tb_exe_pipe.sv */
// reads verif/exe_cases.txt relative to the project root, one case per line
// random stalls and idle gaps come from an lfsr, results are matched in issue order
`timescale 1ns/1ps

module tb_exe_pipe;

    localparam int MAX_CASES = 64;
    // words per case line in the data file
    localparam int COLS      = 14;
    localparam int CLK_NS    = 4;
    localparam int DRAIN_MAX = 64;

    logic              clk;
    logic              i_rst_n;
    logic              i_stall;
    logic              i_op_valid;
    exe_pkg::exe_op_t  i_op;
    exe_pkg::exe_res_t o_res;
    logic              o_res_valid;

    exe_pkg::word_t case_mem [0:MAX_CASES*COLS-1];
    int             num_cases;
    int             pending[$];
    int             cur_case;
    int             err_value;
    int             err_other;
    logic [31:0]    lfsr;

    exe_pipe_top i_exe_pipe_top (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_stall     (i_stall),
        .i_op        (i_op),
        .i_op_valid  (i_op_valid),
        .o_res       (o_res),
        .o_res_valid (o_res_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS/2) clk = ~clk;
    end

    // unused slots get a pattern no case line starts with
    function automatic exe_pkg::word_t fill_word(input int addr);
        fill_word = 32'hdead_0000 ^ addr;
    endfunction

    // galois lfsr, taps of x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b    = lfsr[0];
    endtask

    // flags sit one per hex digit in the af and mf columns
    function automatic exe_pkg::exe_op_t case_op(input int idx);
        exe_pkg::exe_op_t op;
        exe_pkg::word_t   fn;
        exe_pkg::word_t   af;
        exe_pkg::word_t   mf;
        int               b;
        b  = idx * COLS;
        fn = case_mem[b+7];
        af = case_mem[b+8];
        mf = case_mem[b+9];
        op            = '0;
        op.pc         = case_mem[b];
        op.da         = case_mem[b+1];
        op.db         = case_mem[b+2];
        op.imm        = case_mem[b+3];
        op.bpc        = case_mem[b+4];
        op.mem_word   = case_mem[b+5];
        op.jidx       = case_mem[b+6][exe_pkg::JIDX_W-1:0];
        op.alu_func   = fn[15:12];
        op.br_kind    = fn[11:8];
        op.target_reg = fn[4:0];
        op.alu_imm    = af[24];
        op.shift_imm  = af[20];
        op.link       = af[16];
        op.slt        = af[12];
        op.slt_sign   = af[8];
        op.allow_ovf  = af[4];
        op.reg_write  = af[0];
        op.mem_load   = mf[20];
        op.mem_store  = mf[16];
        op.lane_op    = mf[12];
        op.b_hw       = mf[8];
        op.load_sign  = mf[4];
        op.canceled   = mf[0];
        case_op = op;
    endfunction

    task automatic check_word(input string name, input exe_pkg::word_t exp,
                              input exe_pkg::word_t act);
        if (act !== exp) begin
            err_value++;
            $display("MISMATCH %s case %0d: expected 0x%h, got 0x%h", name, cur_case, exp, act);
        end
    endtask

    task automatic check_cause(input string name, input exe_pkg::exc_cause_t exp,
                               input exe_pkg::exc_cause_t act);
        if (act !== exp) begin
            err_value++;
            $display("MISMATCH %s case %0d: expected 0x%h, got 0x%h", name, cur_case, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input exe_pkg::reg_idx_t exp,
                             input exe_pkg::reg_idx_t act);
        if (act !== exp) begin
            err_value++;
            $display("MISMATCH %s case %0d: expected 0x%h, got 0x%h", name, cur_case, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_value++;
            $display("MISMATCH %s case %0d: expected 0x%h, got 0x%h", name, cur_case, exp, act);
        end
    endtask

    // compare the result in o_res against the oldest pending case
    task automatic check_result();
        exe_pkg::word_t    ec;
        exe_pkg::word_t    fn;
        exe_pkg::word_t    af;
        exe_pkg::reg_idx_t exp_reg;
        int                b;
        if (pending.size() == 0) begin
            err_other++;
            $display("result with pc 0x%h came out while no case was pending", o_res.pc);
        end else begin
            cur_case = pending.pop_front();
            b  = cur_case * COLS;
            fn = case_mem[b+7];
            af = case_mem[b+8];
            ec = case_mem[b+11];
            // pc passes through, so it also tags the order
            check_word("o_res.pc", case_mem[b], o_res.pc);
            check_flag("o_res.reg_write", ec[8], o_res.reg_write);
            check_flag("o_res.store_en", ec[4], o_res.store_en);
            check_cause("o_res.cause", ec[3:0], o_res.cause);
            check_word("o_res.next_pc", case_mem[b+13], o_res.next_pc);
            if (ec[8]) begin
                // link always lands in r31
                exp_reg = af[16] ? exe_pkg::LINK_REG : fn[4:0];
                check_word("o_res.wb_data", case_mem[b+10], o_res.wb_data);
                check_reg("o_res.target_reg", exp_reg, o_res.target_reg);
            end
            if (ec[4]) begin
                check_word("o_res.store_word", case_mem[b+12], o_res.store_word);
            end
        end
    endtask

    task automatic report_and_finish();
        $display("checks: %0d value mismatches, %0d other failures", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // a result leaves o_res at the first unstalled edge while it is shown
    always @(posedge clk) begin
        if (i_rst_n && o_res_valid && !i_stall) begin
            check_result();
        end
    end

    initial begin
        int   idx;
        int   drain;
        logic stall_bit;
        logic gap_bit;
        i_rst_n    <= 1'b0;
        i_stall    <= 1'b0;
        i_op_valid <= 1'b0;
        i_op       <= '0;
        lfsr       = 32'h2804_6aed;
        err_value  = 0;
        err_other  = 0;
        cur_case   = -1;
        for (int i = 0; i < MAX_CASES*COLS; i++) begin
            case_mem[i] = fill_word(i);
        end
        $readmemh("verif/exe_cases.txt", case_mem);
        num_cases = 0;
        while (num_cases < MAX_CASES
               && case_mem[num_cases*COLS] != fill_word(num_cases*COLS)) begin
            num_cases++;
        end
        if (num_cases == 0) begin
            err_other++;
            $display("no cases could be read from the data file");
            report_and_finish();
        end
        // watchdog, 20 cycles per case
        fork
            begin
                #(num_cases * 20 * CLK_NS);
                err_other++;
                $display("timeout with %0d cases still pending", pending.size());
                report_and_finish();
            end
        join_none
        repeat (2) @(posedge clk);
        i_rst_n <= 1'b1;
        @(posedge clk);
        // reset values still on the outputs here
        check_flag("o_res_valid", 1'b0, o_res_valid);
        check_flag("o_res.reg_write", 1'b0, o_res.reg_write);
        check_flag("o_res.store_en", 1'b0, o_res.store_en);
        idx = 0;
        while (idx < num_cases) begin
            @(posedge clk);
            // what was driven last cycle got sampled at this edge
            if (i_op_valid && !i_stall) begin
                pending.push_back(idx);
                idx++;
            end
            take_bit(stall_bit);
            take_bit(gap_bit);
            i_stall <= stall_bit;
            if (idx < num_cases && !gap_bit) begin
                i_op       <= case_op(idx);
                i_op_valid <= 1'b1;
            end else begin
                i_op_valid <= 1'b0;
            end
        end
        // let the last results out, still under random stalls
        drain = 0;
        while (pending.size() != 0 && drain < DRAIN_MAX) begin
            @(posedge clk);
            take_bit(stall_bit);
            i_stall <= stall_bit;
            drain++;
        end
        i_stall <= 1'b0;
        repeat (3) @(posedge clk);
        if (pending.size() != 0) begin
            err_other++;
            $display("%0d cases never produced a result", pending.size());
        end
        report_and_finish();
    end

endmodule

/* src/exe_pipe_top.sv */
// two-register execute pipe, latency 2 unstalled edges, i_stall freezes all
`timescale 1ns/1ps

module exe_pipe_top (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_stall,
    input  exe_pkg::exe_op_t  i_op,
    input  logic              i_op_valid,
    output exe_pkg::exe_res_t o_res,
    output logic              o_res_valid
);

    exe_pkg::exe_op_t  op_q;
    logic              op_valid_q;
    exe_pkg::exe_mid_t mid;

    exe_issue_reg i_exe_issue_reg (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_stall    (i_stall),
        .i_op       (i_op),
        .i_op_valid (i_op_valid),
        .o_op       (op_q),
        .o_op_valid (op_valid_q)
    );

    // execute adds no cycle
    exe_stage i_exe_stage (
        .i_op  (op_q),
        .o_mid (mid)
    );

    lane_align i_lane_align (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_stall     (i_stall),
        .i_mid       (mid),
        .i_valid     (op_valid_q),
        .o_res       (o_res),
        .o_res_valid (o_res_valid)
    );

endmodule

/* src/lane_align.sv */
// byte/halfword lane handling and the output register, big-endian lanes
// reg_write and store_en also drop for idle slots
`timescale 1ns/1ps

module lane_align (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_stall,
    input  exe_pkg::exe_mid_t i_mid,
    input  logic              i_valid,
    output exe_pkg::exe_res_t o_res,
    output logic              o_res_valid
);

    logic [1:0]         offset;
    logic [4:0]         lane_sh;
    exe_pkg::word_t     lane_mask;
    exe_pkg::word_t     lane_raw;
    exe_pkg::word_t     load_val;
    exe_pkg::word_t     store_val;
    logic               ext_bit;
    logic               misalign;
    logic               no_exc;
    exe_pkg::exc_cause_t cause_n;
    exe_pkg::exe_res_t  res_n;

    assign offset = i_mid.alu_out[1:0];

    // offset 0 is the top lane, so shift grows as offset shrinks
    assign lane_sh   = i_mid.b_hw ? {~offset[1], 4'b0000} : {~offset, 3'b000};
    assign lane_mask = (i_mid.b_hw ? 32'h0000_ffff : 32'h0000_00ff) << lane_sh;

    // load: bring the lane down, then extend
    assign lane_raw = (i_mid.mem_word & lane_mask) >> lane_sh;
    assign ext_bit  = i_mid.load_sign & (i_mid.b_hw ? lane_raw[15] : lane_raw[7]);

    always_comb begin
        if (!i_mid.lane_op) begin
            load_val = i_mid.mem_word;
        end else if (i_mid.b_hw) begin
            load_val = {{16{ext_bit}}, lane_raw[15:0]};
        end else begin
            load_val = {{24{ext_bit}}, lane_raw[7:0]};
        end
    end

    // store: merge the low lane of db into the memory word
    assign store_val = i_mid.lane_op
        ? ((i_mid.mem_word & ~lane_mask) | ((i_mid.db << lane_sh) & lane_mask))
        : i_mid.db;

    // halfword needs an even offset, word needs offset 0
    assign misalign = (i_mid.mem_load || i_mid.mem_store)
        && (i_mid.lane_op ? (i_mid.b_hw && offset[0]) : (offset != 2'b00));

    // an overflow already recorded wins over misalignment
    always_comb begin
        if (i_mid.cause != exe_pkg::EXC_NONE) begin
            cause_n = i_mid.cause;
        end else if (misalign && !i_mid.canceled) begin
            cause_n = exe_pkg::EXC_DATA_MISALIGN;
        end else begin
            cause_n = exe_pkg::EXC_NONE;
        end
    end

    assign no_exc = i_valid && !i_mid.canceled && (cause_n == exe_pkg::EXC_NONE);

    always_comb begin
        res_n            = '0;
        res_n.pc         = i_mid.pc;
        res_n.wb_data    = i_mid.mem_load ? load_val : i_mid.alu_out;
        res_n.target_reg = i_mid.target_reg;
        res_n.reg_write  = i_mid.reg_write && no_exc;
        res_n.store_en   = i_mid.mem_store && no_exc;
        res_n.store_word = store_val;
        res_n.next_pc    = i_mid.next_pc;
        res_n.cause      = cause_n;
    end

    // output register, holds during a stall
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_res_valid     <= 1'b0;
            o_res.reg_write <= 1'b0;
            o_res.store_en  <= 1'b0;
        end else if (!i_stall) begin
            o_res_valid <= i_valid;
            o_res       <= res_n;
        end
    end

    // decode upstream must never mark an access as both load and store
    a_load_store_excl: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_valid |-> !(i_mid.mem_load && i_mid.mem_store)
    ) else $error("lane_align: mem_load and mem_store both set");

endmodule

/* src/exe_stage.sv */
// combinational execute: operand muxes, alu, slt, link and branch target
// a canceled operation never raises overflow here
`timescale 1ns/1ps

module exe_stage (
    input  exe_pkg::exe_op_t  i_op,
    output exe_pkg::exe_mid_t o_mid
);

    exe_pkg::word_t opd_a;
    exe_pkg::word_t opd_b;
    exe_pkg::word_t alu_result;
    exe_pkg::word_t next_pc;
    logic           alu_ovf;
    logic           lt_signed;
    logic           lt_unsigned;

    // shamt sits in imm[10:6] as in the r-type encoding
    assign opd_a = i_op.shift_imm ? {27'b0, i_op.imm[10:6]} : i_op.da;
    assign opd_b = i_op.alu_imm ? i_op.imm : i_op.db;

    alu i_alu (
        .i_a        (opd_a),
        .i_b        (opd_b),
        .i_func     (i_op.alu_func),
        .o_result   (alu_result),
        .o_overflow (alu_ovf)
    );

    branch_resolve i_branch_resolve (
        .i_kind    (i_op.br_kind),
        .i_pc      (i_op.pc),
        .i_da      (i_op.da),
        .i_db      (i_op.db),
        .i_bpc     (i_op.bpc),
        .i_jidx    (i_op.jidx),
        .o_next_pc (next_pc)
    );

    // set-less-than compares the selected operands
    assign lt_signed   = $signed(opd_a) < $signed(opd_b);
    assign lt_unsigned = opd_a < opd_b;

    always_comb begin
        o_mid            = '0;
        o_mid.pc         = i_op.pc;
        o_mid.db         = i_op.db;
        o_mid.mem_word   = i_op.mem_word;
        o_mid.next_pc    = next_pc;
        o_mid.target_reg = i_op.target_reg;
        // result priority: link, then slt, then alu
        if (i_op.link) begin
            o_mid.alu_out    = i_op.pc + 32'd4;
            o_mid.target_reg = exe_pkg::LINK_REG;
        end else if (i_op.slt) begin
            o_mid.alu_out = {31'b0, i_op.slt_sign ? lt_signed : lt_unsigned};
        end else begin
            o_mid.alu_out = alu_result;
        end
        // overflow only traps for the signed add/sub forms
        if (i_op.allow_ovf && alu_ovf && !i_op.canceled) begin
            o_mid.cause = exe_pkg::EXC_OVERFLOW;
        end else begin
            o_mid.cause = exe_pkg::EXC_NONE;
        end
        o_mid.reg_write = i_op.reg_write;
        o_mid.mem_load  = i_op.mem_load;
        o_mid.mem_store = i_op.mem_store;
        o_mid.lane_op   = i_op.lane_op;
        o_mid.b_hw      = i_op.b_hw;
        o_mid.load_sign = i_op.load_sign;
        o_mid.canceled  = i_op.canceled;
    end

endmodule

/* src/branch_resolve.sv */
// next-pc selection, no delay slot: the jump region comes from the branch pc
`timescale 1ns/1ps

module branch_resolve (
    input  exe_pkg::br_kind_t          i_kind,
    input  exe_pkg::word_t             i_pc,
    input  exe_pkg::word_t             i_da,
    input  exe_pkg::word_t             i_db,
    input  exe_pkg::word_t             i_bpc,
    input  logic [exe_pkg::JIDX_W-1:0] i_jidx,
    output exe_pkg::word_t             o_next_pc
);

    logic da_zero;
    logic da_neg;
    logic da_eq_db;
    logic taken;

    assign da_zero  = (i_da == '0);
    assign da_neg   = i_da[31];
    assign da_eq_db = (i_da == i_db);

    // condition of the conditional kinds
    always_comb begin
        case (i_kind)
            exe_pkg::BR_BEQ:  taken = da_eq_db;
            exe_pkg::BR_BNE:  taken = !da_eq_db;
            exe_pkg::BR_BLEZ: taken = da_neg || da_zero;
            exe_pkg::BR_BGTZ: taken = !da_neg && !da_zero;
            exe_pkg::BR_BLTZ: taken = da_neg;
            exe_pkg::BR_BGEZ: taken = !da_neg;
            exe_pkg::BR_NONE: taken = 1'b0;
            default:          taken = 1'b0;
        endcase
    end

    // target pick, unconditional kinds first
    always_comb begin
        if (i_kind == exe_pkg::BR_J) begin
            o_next_pc = {i_pc[31:28], i_jidx, 2'b00};
        end else if (i_kind == exe_pkg::BR_JR) begin
            o_next_pc = i_da;
        end else if (taken) begin
            o_next_pc = i_bpc;
        end else begin
            // fall through, also for not-taken branches
            o_next_pc = i_pc + 32'd4;
        end
    end

endmodule

/* src/alu.sv */
// integer alu, shifts take their amount from the low 5 bits of i_a
// overflow is only meaningful for add and sub
`timescale 1ns/1ps

module alu (
    input  exe_pkg::word_t     i_a,
    input  exe_pkg::word_t     i_b,
    input  exe_pkg::alu_func_t i_func,
    output exe_pkg::word_t     o_result,
    output logic               o_overflow
);

    exe_pkg::word_t sum;
    exe_pkg::word_t diff;
    logic [4:0]     shamt;

    assign sum   = i_a + i_b;
    assign diff  = i_a - i_b;
    assign shamt = i_a[4:0];

    always_comb begin
        o_result   = '0;
        o_overflow = 1'b0;
        case (i_func)
            exe_pkg::ALU_ADD: begin
                o_result = sum;
                // same operand signs but result sign differs
                o_overflow = (i_a[31] == i_b[31]) && (sum[31] != i_a[31]);
            end
            exe_pkg::ALU_SUB: begin
                o_result = diff;
                // opposite operand signs and result takes the sign of b
                o_overflow = (i_a[31] != i_b[31]) && (diff[31] != i_a[31]);
            end
            exe_pkg::ALU_AND: o_result = i_a & i_b;
            exe_pkg::ALU_OR:  o_result = i_a | i_b;
            exe_pkg::ALU_XOR: o_result = i_a ^ i_b;
            exe_pkg::ALU_NOR: o_result = ~(i_a | i_b);
            // shifts move b, as in the mips sll/srl/sra encoding
            exe_pkg::ALU_SLL: o_result = i_b << shamt;
            exe_pkg::ALU_SRL: o_result = i_b >> shamt;
            exe_pkg::ALU_SRA: o_result = $signed(i_b) >>> shamt;
            default: begin
                // undefined codes give zero
                o_result = '0;
            end
        endcase
    end

endmodule

/* src/exe_issue_reg.sv */
// input register, frozen while i_stall is high
// only the valid bit is reset, the operation payload is not
`timescale 1ns/1ps

module exe_issue_reg (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic             i_stall,
    input  exe_pkg::exe_op_t i_op,
    input  logic             i_op_valid,
    output exe_pkg::exe_op_t o_op,
    output logic             o_op_valid
);

    // valid bit follows the input on every unstalled edge
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_op_valid <= 1'b0;
        end else if (!i_stall) begin
            o_op_valid <= i_op_valid;
        end
    end

    // operation payload, loaded alongside the valid bit
    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_op <= i_op;
        end
    end

    // downstream gating of reg_write and store_en relies on a clean valid
    a_valid_known: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        !$isunknown(o_op_valid)
    ) else $error("exe_issue_reg: o_op_valid unknown after reset");

endmodule

/* src/exe_pkg.sv */
// shared widths, codes and structs of the execute pipeline
// lane numbering is big-endian, offset 0 is the most significant byte
package exe_pkg;

    // plain vector types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  alu_func_t;
    typedef logic [3:0]  br_kind_t;
    typedef logic [3:0]  exc_cause_t;

    localparam int JIDX_W = 26;
    localparam reg_idx_t LINK_REG = 5'd31;

    // alu function codes
    localparam alu_func_t ALU_ADD = 4'd0;
    localparam alu_func_t ALU_SUB = 4'd1;
    localparam alu_func_t ALU_AND = 4'd2;
    localparam alu_func_t ALU_OR  = 4'd3;
    localparam alu_func_t ALU_XOR = 4'd4;
    localparam alu_func_t ALU_NOR = 4'd5;
    localparam alu_func_t ALU_SLL = 4'd6;
    localparam alu_func_t ALU_SRL = 4'd7;
    localparam alu_func_t ALU_SRA = 4'd8;

    // branch kinds, the linking variants reuse these with link set
    localparam br_kind_t BR_NONE = 4'd0;
    localparam br_kind_t BR_J    = 4'd1;
    localparam br_kind_t BR_JR   = 4'd2;
    localparam br_kind_t BR_BEQ  = 4'd3;
    localparam br_kind_t BR_BNE  = 4'd4;
    localparam br_kind_t BR_BLEZ = 4'd5;
    localparam br_kind_t BR_BGTZ = 4'd6;
    localparam br_kind_t BR_BLTZ = 4'd7;
    localparam br_kind_t BR_BGEZ = 4'd8;

    // exception causes
    localparam exc_cause_t EXC_NONE          = 4'd0;
    localparam exc_cause_t EXC_OVERFLOW      = 4'd7;
    localparam exc_cause_t EXC_DATA_MISALIGN = 4'd8;

    // one decoded operation as issued into the pipe
    typedef struct packed {
        word_t              pc;
        word_t              da;
        word_t              db;
        word_t              imm;
        // taken target of a conditional branch
        word_t              bpc;
        // memory word at the data address
        word_t              mem_word;
        logic [JIDX_W-1:0]  jidx;
        alu_func_t          alu_func;
        br_kind_t           br_kind;
        reg_idx_t           target_reg;
        logic               alu_imm;
        logic               shift_imm;
        logic               link;
        logic               slt;
        logic               slt_sign;
        logic               allow_ovf;
        logic               reg_write;
        logic               mem_load;
        logic               mem_store;
        logic               lane_op;
        logic               b_hw;
        logic               load_sign;
        logic               canceled;
    } exe_op_t;

    // execute result handed to the lane stage
    typedef struct packed {
        word_t      pc;
        word_t      alu_out;
        word_t      db;
        word_t      mem_word;
        word_t      next_pc;
        reg_idx_t   target_reg;
        exc_cause_t cause;
        logic       reg_write;
        logic       mem_load;
        logic       mem_store;
        logic       lane_op;
        logic       b_hw;
        logic       load_sign;
        logic       canceled;
    } exe_mid_t;

    // registered pipe output
    typedef struct packed {
        word_t      pc;
        word_t      wb_data;
        reg_idx_t   target_reg;
        logic       reg_write;
        logic       store_en;
        word_t      store_word;
        word_t      next_pc;
        exc_cause_t cause;
    } exe_res_t;

endpackage
